//--- apu_frame_top.f
+incdir+design
design/apu_pkg.sv
design/apu_framecounter.sv
design/apu_channel.sv
design/apu_mixer.sv
design/apu_frame_top.sv
testbench/tb_clock.sv
testbench/apu_frame_checker.sv
testbench/apu_frame_tb.sv

//--- design/apu_channel.sv
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_channel #(
    parameter int ch_index = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            apu_addr,
    input  logic [7:0]            data_in,
    input  logic                  apu_wr,
    input  logic                  qtrframe,
    input  logic                  halfframe,
    output logic [`APU_VOL_W-1:0] vol,
    output logic                  active
);

    import apu_pkg::*;

    // this channel's register addresses
    localparam logic [4:0] ctrl_addr = 5'(REG_CH0_CTRL + 4 * ch_index);
    localparam logic [4:0] len_addr  = 5'(REG_CH0_LEN + 4 * ch_index);

    // classic length values, indexed by data bits 7..3
    localparam logic [`APU_LEN_W-1:0] len_table [32] = '{
        8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
        8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
        8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
        8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
    };

    logic ctrl_wr;
    logic len_wr;
    logic status_wr;
    assign ctrl_wr   = (apu_addr == ctrl_addr) && apu_wr;
    assign len_wr    = (apu_addr == len_addr) && apu_wr;
    assign status_wr = (apu_addr == REG_STATUS) && apu_wr;

    // control register fields
    logic                  halt_loop;
    logic                  const_vol;
    logic [`APU_VOL_W-1:0] vol_period;

    logic                  enable;
    logic [`APU_LEN_W-1:0] len_cnt;

    env_state_e            env_state;
    logic [`APU_VOL_W-1:0] env_div;
    logic [`APU_VOL_W-1:0] decay;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_loop  <= 1'b0;
            const_vol  <= 1'b0;
            vol_period <= '0;
            enable     <= 1'b0;
            len_cnt    <= '0;
            env_state  <= ENV_HOLD;
            env_div    <= '0;
            decay      <= '0;
        end else begin
            if (ctrl_wr) begin
                halt_loop  <= data_in[5];
                const_vol  <= data_in[4];
                vol_period <= data_in[3:0];
            end

            // length counter, halt bit freezes it
            if (halfframe && len_cnt != '0 && !halt_loop) begin
                len_cnt <= len_cnt - 1'b1;
            end
            if (len_wr && enable) begin
                len_cnt <= len_table[data_in[7:3]];
            end

            // enable from status write, disable kills length at once
            if (status_wr) begin
                enable <= data_in[ch_index];
                if (!data_in[ch_index]) begin
                    len_cnt <= '0;
                end
            end

            // envelope clocked by quarter frames
            if (qtrframe) begin
                if (env_state == ENV_START) begin
                    decay     <= '1;
                    env_div   <= vol_period;
                    env_state <= ENV_DECAY;
                end else if (env_div == '0) begin
                    env_div <= vol_period;
                    if (decay != '0) begin
                        decay <= decay - 1'b1;
                    end else if (halt_loop) begin
                        // loop bit doubles as halt
                        decay     <= '1;
                        env_state <= ENV_DECAY;
                    end else begin
                        env_state <= ENV_HOLD;
                    end
                end else begin
                    env_div <= env_div - 1'b1;
                end
            end
            // length load restarts the envelope
            if (len_wr && enable) begin
                env_state <= ENV_START;
            end
        end
    end

    // silent once the length runs out
    assign active = (len_cnt != '0);
    assign vol    = !active ? '0 : (const_vol ? vol_period : decay);

endmodule

//--- design/apu_defines.svh
`ifndef APU_DEFINES_SVH
`define APU_DEFINES_SVH

// channel units, one status bit each in bits 3..0
`define APU_NUM_CH 4

// envelope volume / period width
`define APU_VOL_W 4

// length counter width
`define APU_LEN_W 8

// mix level, four 4-bit volumes max out at 60
`define APU_MIX_W 6

`endif

//--- design/apu_frame_top.sv
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_frame_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            apu_addr,
    input  logic [7:0]            data_in,
    input  logic                  apu_rd,
    input  logic                  apu_wr,
    output logic [7:0]            rd_data,
    output logic [`APU_MIX_W-1:0] mix,
    output logic                  irq
);

    // frame strobes to every channel
    logic qtrframe;
    logic halfframe;

    // flat channel outputs toward the mixer
    logic [`APU_NUM_CH*`APU_VOL_W-1:0] vols;
    logic [`APU_NUM_CH-1:0]           actives;

    // sequencer, apu_cycle toggle not needed past this point
    apu_framecounter framecounter_i (
        .clk       (clk),
        .rst       (rst),
        .apu_addr  (apu_addr),
        .data_in   (data_in),
        .apu_rd    (apu_rd),
        .apu_wr    (apu_wr),
        .apu_cycle (),
        .qtrframe  (qtrframe),
        .halfframe (halfframe),
        .irq       (irq)
    );

    // one unit per status bit
    for (genvar i = 0; i < `APU_NUM_CH; i++) begin : g_ch
        apu_channel #(
            .ch_index (i)
        ) channel_i (
            .clk       (clk),
            .rst       (rst),
            .apu_addr  (apu_addr),
            .data_in   (data_in),
            .apu_wr    (apu_wr),
            .qtrframe  (qtrframe),
            .halfframe (halfframe),
            .vol       (vols[i*`APU_VOL_W +: `APU_VOL_W]),
            .active    (actives[i])
        );
    end

    apu_mixer mixer_i (
        .clk      (clk),
        .rst      (rst),
        .apu_addr (apu_addr),
        .apu_rd   (apu_rd),
        .irq      (irq),
        .vols     (vols),
        .actives  (actives),
        .mix      (mix),
        .rd_data  (rd_data)
    );

endmodule

//--- design/apu_framecounter.sv
`timescale 1ns/1ps

module apu_framecounter (
    input  logic       clk,
    input  logic       rst,
    input  logic [4:0] apu_addr,
    input  logic [7:0] data_in,
    input  logic       apu_rd,
    input  logic       apu_wr,
    output logic       apu_cycle,
    output logic       qtrframe,
    output logic       halfframe,
    output logic       irq
);

    import apu_pkg::*;

    // frame register write and status read decodes
    logic frame_wr;
    logic status_rd;
    assign frame_wr  = (apu_addr == REG_FRAME) && apu_wr;
    assign status_rd = (apu_addr == REG_STATUS) && apu_rd;

    // 0 = 4-step with irq, 1 = 5-step
    logic mode;
    logic mask_irq;

    logic [15:0] frame_cnt;
    // frame write waits here for an apu cycle
    logic restart_pending;

    // wrap runs over three cycles so irq is set three times
    // flag at last count, then restart, then count 0
    logic wrap_flag;
    logic wrap_cycle;
    logic wrap_cycle_d;

    logic irq_set;
    logic restart_now;

    assign irq_set     = (wrap_flag || wrap_cycle || wrap_cycle_d) && !mode;
    assign restart_now = apu_cycle && restart_pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            apu_cycle       <= 1'b0;
            restart_pending <= 1'b0;
            frame_cnt       <= '0;
            irq             <= 1'b0;
            mode            <= 1'b0;
            mask_irq        <= 1'b0;
            wrap_cycle      <= 1'b0;
            wrap_cycle_d    <= 1'b0;
        end else begin
            // cpu rate toggle
            apu_cycle    <= ~apu_cycle;
            wrap_cycle   <= wrap_flag;
            wrap_cycle_d <= wrap_cycle;

            if (frame_wr) begin
                mode            <= data_in[7];
                mask_irq        <= data_in[6];
                restart_pending <= 1'b1;
            end

            // restart on a pending write or on wrap
            if (restart_now || wrap_cycle) begin
                frame_cnt       <= '0;
                restart_pending <= 1'b0;
            end else begin
                frame_cnt <= frame_cnt + 16'd1;
            end

            // set wins over a same-cycle status read
            if (irq_set) begin
                irq <= 1'b1;
            end else if (status_rd) begin
                irq <= 1'b0;
            end
            // mask overrides everything
            if (mask_irq) begin
                irq <= 1'b0;
            end
        end
    end

    always_comb begin
        // strobes after wrap, and right away on a mode 1 restart
        qtrframe  = wrap_cycle || (mode && restart_now);
        halfframe = wrap_cycle || (mode && restart_now);
        wrap_flag = 1'b0;
        case (frame_cnt)
            16'd7456: qtrframe = 1'b1;
            16'd14913: begin
                qtrframe  = 1'b1;
                halfframe = 1'b1;
            end
            16'd22371: qtrframe = 1'b1;
            // 4-step wrap point
            16'd29828: wrap_flag = !mode;
            // 5-step wrap point, never reached in mode 0
            16'd37280: wrap_flag = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- design/apu_mixer.sv
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_mixer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [4:0]                       apu_addr,
    input  logic                             apu_rd,
    input  logic                             irq,
    input  logic [`APU_NUM_CH*`APU_VOL_W-1:0] vols,
    input  logic [`APU_NUM_CH-1:0]           actives,
    output logic [`APU_MIX_W-1:0]            mix,
    output logic [7:0]                       rd_data
);

    import apu_pkg::*;

    logic                  status_rd;
    logic [`APU_MIX_W-1:0] vol_sum;

    assign status_rd = (apu_addr == REG_STATUS) && apu_rd;

    // linear sum of all channel volumes
    always_comb begin
        vol_sum = '0;
        for (int i = 0; i < `APU_NUM_CH; i++) begin
            vol_sum = vol_sum + `APU_MIX_W'(vols[i*`APU_VOL_W +: `APU_VOL_W]);
        end
    end

    // mix lags the volumes by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mix <= '0;
        end else begin
            mix <= vol_sum;
        end
    end

    // status byte, valid in the read cycle itself
    // irq in bit 6, length active bits at the bottom
    always_comb begin
        rd_data = 8'h00;
        if (status_rd) begin
            rd_data[6]              = irq;
            rd_data[`APU_NUM_CH-1:0] = actives;
        end
    end

endmodule

//--- design/apu_pkg.sv
package apu_pkg;

    // register map, channel n at 4n (control) and 4n+3 (length load)
    typedef enum logic [4:0] {
        REG_CH0_CTRL = 5'h00,
        REG_CH0_LEN  = 5'h03,
        REG_CH1_CTRL = 5'h04,
        REG_CH1_LEN  = 5'h07,
        REG_CH2_CTRL = 5'h08,
        REG_CH2_LEN  = 5'h0B,
        REG_CH3_CTRL = 5'h0C,
        REG_CH3_LEN  = 5'h0F,
        // enables on write, active bits and irq on read
        REG_STATUS   = 5'h15,
        // mode in bit 7, irq mask in bit 6
        REG_FRAME    = 5'h17
    } apu_reg_e;

    // envelope unit states
    typedef enum logic [1:0] {
        // restart pending, taken on next quarter frame
        ENV_START,
        // divider running, decay level counting down
        ENV_DECAY,
        // decay stuck at zero, no loop
        ENV_HOLD
    } env_state_e;

endpackage

//--- run_sim.sh
#!/bin/sh
# compile and run the apu frame testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f apu_frame_top.f --top-module apu_frame_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vapu_frame_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
else
    exit 1
fi

//--- testbench/apu_frame_checker.sv
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_frame_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [2:0]            chk_mask,
    input  logic [127:0]          test_name,
    input  logic [7:0]            exp_rd,
    input  logic                  exp_irq,
    input  logic [`APU_MIX_W-1:0] exp_mix,
    input  logic [7:0]            rd_data,
    input  logic                  irq,
    input  logic [`APU_MIX_W-1:0] mix,
    output int                    mismatches
);

    int err_cnt = 0;

    assign mismatches = err_cnt;

    // values seen here are the ones of the cycle that ends at this edge
    // mask bit 0 rd_data, bit 1 irq, bit 2 mix
    always @(posedge clk) begin
        if (!rst) begin
            if (chk_mask[0] && rd_data !== exp_rd) begin
                $display("Fail %0s: rd_data expected 0x%02h, actual 0x%02h",
                         test_name, exp_rd, rd_data);
                err_cnt = err_cnt + 1;
            end
            if (chk_mask[1] && irq !== exp_irq) begin
                $display("Fail %0s: irq expected %0b, actual %0b", test_name, exp_irq, irq);
                err_cnt = err_cnt + 1;
            end
            // mix is registered, lags the volumes by a cycle
            if (chk_mask[2] && mix !== exp_mix) begin
                $display("Fail %0s: mix expected %0d, actual %0d", test_name, exp_mix, mix);
                err_cnt = err_cnt + 1;
            end
        end
    end

endmodule

//--- testbench/apu_frame_tb.sv
`timescale 1ns/1ps
`include "apu_defines.svh"

module apu_frame_tb;

    localparam int wd_margin = 1000;
    localparam int max_lines = 64;

    logic                  clk;
    logic                  rst;
    logic [4:0]            apu_addr;
    logic [7:0]            data_in;
    logic                  apu_rd;
    logic                  apu_wr;
    logic [7:0]            rd_data;
    logic [`APU_MIX_W-1:0] mix;
    logic                  irq;

    // expectations for the cycle being driven
    logic [2:0]            chk_mask;
    logic [127:0]          test_name;
    logic [7:0]            exp_rd;
    logic                  exp_irq;
    logic [`APU_MIX_W-1:0] exp_mix;
    int                    mismatches;

    // trace rows, columns as in the file minus the name
    int           t_val  [max_lines][9];
    logic [127:0] t_name [max_lines];
    int           n_lines = 0;
    int           last_cycle = 0;
    int           other_errors = 0;
    int           cyc;
    logic         loaded = 1'b0;

    tb_clock clock_i (.clk(clk));

    apu_frame_top apu_frame_top_i (
        .clk      (clk),
        .rst      (rst),
        .apu_addr (apu_addr),
        .data_in  (data_in),
        .apu_rd   (apu_rd),
        .apu_wr   (apu_wr),
        .rd_data  (rd_data),
        .mix      (mix),
        .irq      (irq)
    );

    apu_frame_checker checker_i (
        .clk        (clk),
        .rst        (rst),
        .chk_mask   (chk_mask),
        .test_name  (test_name),
        .exp_rd     (exp_rd),
        .exp_irq    (exp_irq),
        .exp_mix    (exp_mix),
        .rd_data    (rd_data),
        .irq        (irq),
        .mix        (mix),
        .mismatches (mismatches)
    );

    task automatic load_trace();
        int           fd;
        int           cnt;
        int           v [9];
        logic [127:0] nm;
        string        line;
        fd = $fopen("testbench/apu_frame_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open testbench/apu_frame_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%d %h %h %d %d %d %h %d %d %s",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], nm);
                if (cnt != 10 || n_lines >= max_lines) begin
                    $display("error: trace line not understood: %s", line);
                    other_errors++;
                end else begin
                    t_val[n_lines] = v;
                    t_name[n_lines] = nm;
                    last_cycle = v[0];
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // bus quiet, nothing checked
    task automatic drive_idle();
        apu_addr = '0;
        data_in  = '0;
        apu_rd   = 1'b0;
        apu_wr   = 1'b0;
        chk_mask = '0;
    endtask

    task automatic apply_line(input int i);
        apu_addr  = 5'(t_val[i][1]);
        data_in   = 8'(t_val[i][2]);
        apu_rd    = t_val[i][3] != 0;
        apu_wr    = t_val[i][4] != 0;
        chk_mask  = 3'(t_val[i][5]);
        exp_rd    = 8'(t_val[i][6]);
        exp_irq   = t_val[i][7] != 0;
        exp_mix   = `APU_MIX_W'(t_val[i][8]);
        test_name = t_name[i];
    endtask

    initial begin
        rst       = 1'b1;
        exp_rd    = '0;
        exp_irq   = 1'b0;
        exp_mix   = '0;
        test_name = '0;
        drive_idle();
        load_trace();
        if (n_lines == 0) begin
            $display("error: trace holds no entries");
            other_errors++;
        end
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        // cycle 0 starts at this falling edge
        @(negedge clk);
        rst = 1'b0;
        cyc = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (t_val[i][0] < cyc) begin
                $display("error: trace entry %0s is out of cycle order", t_name[i]);
                other_errors++;
            end
            while (cyc < t_val[i][0]) begin
                drive_idle();
                @(negedge clk);
                cyc++;
            end
            apply_line(i);
            @(negedge clk);
            cyc++;
        end
        drive_idle();
        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog, last trace cycle plus a fixed margin
    initial begin
        wait (loaded);
        repeat (last_cycle + wd_margin) @(posedge clk);
        $display("timeout: trace not finished within %0d cycles", last_cycle + wd_margin);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- testbench/apu_frame_trace.txt
# cycle addr(hex) data(hex) rd wr mask exp_rd(hex) exp_irq exp_mix name
# mask 1 = rd_data, 2 = irq, 4 = mix; cycle 0 is the first cycle out of reset
2     15 0f 0 1 0 00 0 0  enable_all
3     00 31 0 1 0 00 0 0  ch0_ctrl
4     04 32 0 1 0 00 0 0  ch1_ctrl
5     08 33 0 1 0 00 0 0  ch2_ctrl
6     0c 34 0 1 0 00 0 0  ch3_ctrl
7     03 08 0 1 0 00 0 0  ch0_len
8     07 08 0 1 0 00 0 0  ch1_len
9     0b 08 0 1 0 00 0 0  ch2_len
10    0f 08 0 1 0 00 0 0  ch3_len
12    15 00 1 0 7 0f 0 10 const_mix
14    15 0b 0 1 0 00 0 0  ch2_disable
16    15 00 1 0 7 0b 0 7  status_disable
17    15 0f 0 1 0 00 0 0  ch2_enable
18    08 00 0 1 0 00 0 0  env_ctrl
19    0b 08 0 1 0 00 0 0  env_len
20    17 00 0 1 0 00 0 0  frame_mode0
7480  00 00 0 0 4 00 0 22 env_qtr1
14937 00 00 0 0 4 00 0 21 env_qtr2
22395 00 00 0 0 4 00 0 20 env_qtr3
29851 15 00 1 0 7 4f 1 20 irq_set
29853 15 00 1 0 7 4f 1 19 irq_read
29854 00 00 0 0 7 00 0 19 irq_cleared
29858 15 0b 0 1 0 00 0 0  ch2_silence
29860 17 40 0 1 0 00 0 0  frame_masked
59691 15 00 1 0 7 0b 0 7  irq_masked
59700 0c 14 0 1 0 00 0 0  len2_ctrl
59702 0f 18 0 1 0 00 0 0  len2_load
59704 17 80 0 1 0 00 0 0  frame_mode1
59706 15 00 1 0 7 0b 0 7  mode1_start
74621 15 00 1 0 7 03 0 3  len2_expired
96990 15 00 1 0 7 03 0 3  mode1_no_irq

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 100 ns period, first rising edge at 50 ns
    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

endmodule
